/* src.f */
hw/rv_pkg.sv
hw/rv_result_if.sv
hw/rv_frontend.sv
hw/rv_regfile.sv
hw/rv_execute.sv
hw/rv_mem_wb.sv
hw/rv_core.sv
test/rv_core_chk.sv
test/rv_core_tb.sv

/* run.sh */
#!/bin/sh
# build and run the rv_core testbench with Verilator
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert -f src.f --top-module rv_core_tb -o sim_rv_core

out=$(./obj_dir/sim_rv_core)
echo "$out"

# pass only if the testbench reported success
echo "$out" | grep -q "Simulation completed successfully"

/* test/program_vectors.hex */
// words 0-63 memory image, 64-127 retired pcs, 128-143 store (address, data) pairs
// all-ones ends a list
// 0x00 alu chains with stores to 0xd8 0xdc 0xe0
123450B7 67808113 401101B3 0C202C23 00419213 0C302E23 FF800313 40135393
01C35413 008324B3 00833533 0043C5B3 0EB02023 00941633 409356B3 00935733
00B777B3 00C7E833 0FF84893 7F08F913 70596993 FF932A13 01043A93 015A0B33
// 0x60 store to 0xe4, then six branch pairs, not taken then taken
013B0BB3 0F702223 00A48463 00768463 0E002C23 00769463 00A49463 0E002C23
00644463 00834463 0E002C23 00835463 00645463 0E002C23 00836463 00646463
// 0xb0 loads used at once and stored onward, ecall at 0xd0
0E002C23 00647463 00837463 0E002C23 0F002C03 018C0CB3 0F902423 0E002D03
0FA02623 0E802D83 001D8E13 0FC02A23 00000073 00000000 00000000 00000000
// data, load source at 0xf0
00000000 00000000 00000000 00000000 01234567 00000000 00000000 00000000
// retired pcs
00000000 00000004 00000008 0000000C 00000010 00000014 00000018 0000001C
00000020 00000024 00000028 0000002C 00000030 00000034 00000038 0000003C
00000040 00000044 00000048 0000004C 00000050 00000054 00000058 0000005C
00000060 00000064 00000068 0000006C 00000074 00000078 00000080 00000084
0000008C 00000090 00000098 0000009C 000000A4 000000A8 000000B0 000000B4
000000B8 000000BC 000000C0 000000C4 000000C8 000000CC 000000D0 FFFFFFFF
FFFFFFFF FFFFFFFF FFFFFFFF FFFFFFFF FFFFFFFF FFFFFFFF FFFFFFFF FFFFFFFF
FFFFFFFF FFFFFFFF FFFFFFFF FFFFFFFF FFFFFFFF FFFFFFFF FFFFFFFF FFFFFFFF
// store pairs in program order
000000D8 12345678 000000DC 00000678 000000E0 FFFF987C 000000E4 00000787
000000E8 02468ACE 000000EC FFFF987C 000000F4 02468ACF FFFFFFFF FFFFFFFF

/* test/rv_core_tb.sv */
`timescale 1ns/1ps

module rv_core_tb;

  localparam rv_pkg::word_t RESET_PC = 32'h0000_0000;
  localparam int MEM_WORDS = 64;
  // vector file: memory image, retired pcs, store pairs
  localparam int PC_BASE = 64;
  localparam int PC_SLOTS = 64;
  localparam int ST_BASE = 128;
  localparam int ST_PAIRS = 8;
  localparam int VEC_WORDS = 144;
  // word 62 is never touched by the program
  localparam int RAND_IDX = 62;
  localparam int TIMEOUT = 500;

  logic                  clk;
  logic                  rst;
  rv_pkg::word_t         pc;
  rv_pkg::insn_t         insn;
  rv_pkg::word_t         dmem_addr;
  rv_pkg::word_t         dmem_rdata;
  rv_pkg::word_t         dmem_wdata;
  rv_pkg::byte_en_t      dmem_we;
  logic                  halt;
  rv_pkg::word_t         trace_pc;
  rv_pkg::insn_t         trace_insn;
  rv_pkg::cycle_status_e trace_status;

  logic [31:0] vec [0:VEC_WORDS-1];
  logic [31:0] mem [0:MEM_WORDS-1];
  logic [31:0] rand_word;
  logic [31:0] exp_pc;
  logic [31:0] nxt_pc;
  int seed;
  int errors = 0;
  int n_pc_exp = 0;
  int n_st_exp = 0;
  int n_ret = 0;
  int n_st = 0;
  int live = 0;
  int bubbles = 0;
  int wait_cycles;
  logic done = 1'b0;
  logic last;

  rv_core #(
    .RESET_PC (RESET_PC)
  ) UUT (
    .clk          (clk),
    .rst          (rst),
    .pc           (pc),
    .insn         (insn),
    .dmem_addr    (dmem_addr),
    .dmem_rdata   (dmem_rdata),
    .dmem_wdata   (dmem_wdata),
    .dmem_we      (dmem_we),
    .halt         (halt),
    .trace_pc     (trace_pc),
    .trace_insn   (trace_insn),
    .trace_status (trace_status)
  );

  task automatic check_eq(input string name, input logic [31:0] exp, input logic [31:0] act);
    if (exp !== act) begin
      $display("Mismatch %s: expected %h, got %h", name, exp, act);
      errors++;
    end
  endtask

  initial begin
    clk = 1'b0;
    forever #4 clk = ~clk;
  end

  // trace and store checking, then the memory model
  always @(negedge clk) begin
    if (!rst && !done) begin
      if (live < 4) begin
        live++;
      end
      if (live == 4) begin
        if (bubbles > 0) begin
          check_eq("trace_status", 32'(rv_pkg::CYCLE_TAKEN_BRANCH), 32'(trace_status));
          check_eq("halt", 0, 32'(halt));
          bubbles--;
        end else if (trace_status == rv_pkg::CYCLE_NO_STALL) begin
          if (n_ret >= n_pc_exp) begin
            $display("more instructions retired than expected, pc %h", trace_pc);
            errors++;
            done = 1'b1;
          end else begin
            exp_pc = vec[PC_BASE + n_ret];
            nxt_pc = (n_ret + 1 < PC_SLOTS) ? vec[PC_BASE + n_ret + 1] : '1;
            last = (nxt_pc == '1);
            check_eq("trace_pc", exp_pc, trace_pc);
            check_eq("trace_insn", vec[exp_pc[7:2]], trace_insn);
            check_eq("halt", 32'(last), 32'(halt));
            // a jump in the expected pcs means a taken branch
            if (!last && nxt_pc != exp_pc + 32'd4) begin
              bubbles = 2;
            end
            n_ret++;
            if (last || halt) begin
              done = 1'b1;
            end
          end
        end else begin
          check_eq("trace_status", 32'(rv_pkg::CYCLE_NO_STALL), 32'(trace_status));
        end
      end
      if (dmem_we != 4'b0000) begin
        if (n_st < ST_PAIRS) begin
          check_eq("dmem_addr", vec[ST_BASE + 2 * n_st], dmem_addr);
          check_eq("dmem_wdata", vec[ST_BASE + 2 * n_st + 1], dmem_wdata);
        end else begin
          $display("unexpected extra store to address %h", dmem_addr);
          errors++;
        end
        if (dmem_addr[31:8] != 24'd0) begin
          $display("store outside the memory model at %h", dmem_addr);
          errors++;
        end
        n_st++;
      end
    end
    // read-first data port
    dmem_rdata <= mem[dmem_addr[7:2]];
    if (dmem_we != 4'b0000) begin
      mem[dmem_addr[7:2]] = dmem_wdata;
    end
    insn <= mem[pc[7:2]];
  end

  initial begin
    rst = 1'b1;
    insn = '0;
    dmem_rdata = '0;
    $readmemh("test/program_vectors.hex", vec);
    for (int i = 0; i < MEM_WORDS; i++) begin
      mem[i] = vec[i];
    end
    while (n_pc_exp < PC_SLOTS && vec[PC_BASE + n_pc_exp] != '1) begin
      n_pc_exp++;
    end
    while (n_st_exp < ST_PAIRS && vec[ST_BASE + 2 * n_st_exp] != '1) begin
      n_st_exp++;
    end
    seed = 32'hfc525935;
    rand_word = $random(seed);
    mem[RAND_IDX] = rand_word;

    repeat (5) @(negedge clk);
    rst <= 1'b0;
    check_eq("pc", RESET_PC, pc);
    // reset bubbles drain through the four stages
    for (int i = 0; i < 4; i++) begin
      if (i > 0) begin
        @(negedge clk);
      end
      check_eq("trace_status", 32'(rv_pkg::CYCLE_RESET), 32'(trace_status));
      check_eq("halt", 0, 32'(halt));
      check_eq("dmem_we", 0, 32'(dmem_we));
    end

    for (wait_cycles = 0; wait_cycles < TIMEOUT && !done; wait_cycles++) begin
      @(posedge clk);
    end
    if (!done) begin
      $display("timeout: halt never came within %0d cycles", TIMEOUT);
      errors++;
    end else begin
      check_eq("retired_count", n_pc_exp, n_ret);
      check_eq("store_count", n_st_exp, n_st);
      for (int i = 0; i < n_st_exp; i++) begin
        check_eq("mem", vec[ST_BASE + 2 * i + 1], mem[vec[ST_BASE + 2 * i][7:2]]);
      end
      check_eq("mem_rand_word", rand_word, mem[RAND_IDX]);
    end

    $display("errors: %0d", errors);
    if (errors == 0) begin
      $display("Simulation completed successfully");
    end else begin
      $display("Simulation failed");
    end
    $finish;
  end

endmodule

/* test/rv_core_chk.sv */
`timescale 1ns/1ps

// protocol checks on the rv_core outputs
module rv_core_chk (
  input logic                  clk,
  input logic                  rst,
  input rv_pkg::byte_en_t      dmem_we,
  input rv_pkg::word_t         dmem_addr,
  input rv_pkg::cycle_status_e trace_status
);

  int unsigned since_rst;

  // cycles since reset was released, saturating
  always @(posedge clk) begin
    if (rst) begin
      since_rst <= 0;
    end else if (since_rst < 255) begin
      since_rst <= since_rst + 1;
    end
  end

  // only whole-word stores exist
  we_whole_word: assert property (@(posedge clk) disable iff (rst)
    (dmem_we == 4'b0000) || (dmem_we == 4'b1111))
    else $error("dmem_we is neither zero nor all-ones");

  we_aligned: assert property (@(posedge clk) disable iff (rst)
    (dmem_we != 4'b0000) |-> (dmem_addr[1:0] == 2'b00))
    else $error("store to a misaligned address");

  // reset bubbles drain out of writeback after four cycles
  reset_drained: assert property (@(posedge clk) disable iff (rst)
    (since_rst >= 4) |-> (trace_status != rv_pkg::CYCLE_RESET))
    else $error("reset bubble seen late on the trace");

endmodule

bind rv_core rv_core_chk chk (
  .clk          (clk),
  .rst          (rst),
  .dmem_we      (dmem_we),
  .dmem_addr    (dmem_addr),
  .trace_status (trace_status)
);

/* hw/rv_core.sv */
`timescale 1ns/1ps

// five-stage rv32i core; memories sit outside
module rv_core #(
  parameter rv_pkg::word_t RESET_PC = 32'h0000_0000
) (
  input  logic                  clk,
  input  logic                  rst,
  output rv_pkg::word_t         pc,
  input  rv_pkg::insn_t         insn,
  output rv_pkg::word_t         dmem_addr,
  input  rv_pkg::word_t         dmem_rdata,
  output rv_pkg::word_t         dmem_wdata,
  output rv_pkg::byte_en_t      dmem_we,
  output logic                  halt,
  output rv_pkg::word_t         trace_pc,
  output rv_pkg::insn_t         trace_insn,
  output rv_pkg::cycle_status_e trace_status
);

  logic                  flush;
  rv_pkg::word_t         target;
  rv_pkg::word_t         d_pc;
  rv_pkg::insn_t         d_insn;
  rv_pkg::cycle_status_e d_status;
  rv_pkg::reg_idx_t      rs1;
  rv_pkg::reg_idx_t      rs2;
  rv_pkg::word_t         rs1_data;
  rv_pkg::word_t         rs2_data;
  rv_pkg::insn_t         x_insn;
  rv_pkg::word_t         x_pc;
  rv_pkg::cycle_status_e x_status;
  rv_pkg::word_t         x_result;
  rv_pkg::word_t         x_store_data;

  // memory and writeback results travel back on this bundle
  rv_result_if res ();

  rv_frontend #(
    .RESET_PC (RESET_PC)
  ) frontend (
    .clk      (clk),
    .rst      (rst),
    .flush    (flush),
    .target   (target),
    .pc       (pc),
    .insn     (insn),
    .d_pc     (d_pc),
    .d_insn   (d_insn),
    .d_status (d_status)
  );

  rv_regfile regfile (
    .clk      (clk),
    .rst      (rst),
    .rs1      (rs1),
    .rs2      (rs2),
    .rs1_data (rs1_data),
    .rs2_data (rs2_data),
    .res      (res)
  );

  rv_execute execute (
    .clk          (clk),
    .rst          (rst),
    .d_pc         (d_pc),
    .d_insn       (d_insn),
    .d_status     (d_status),
    .rs1          (rs1),
    .rs2          (rs2),
    .rs1_data     (rs1_data),
    .rs2_data     (rs2_data),
    .res          (res),
    .flush        (flush),
    .target       (target),
    .x_insn       (x_insn),
    .x_pc         (x_pc),
    .x_status     (x_status),
    .x_result     (x_result),
    .x_store_data (x_store_data)
  );

  rv_mem_wb mem_wb (
    .clk          (clk),
    .rst          (rst),
    .x_insn       (x_insn),
    .x_pc         (x_pc),
    .x_status     (x_status),
    .x_result     (x_result),
    .x_store_data (x_store_data),
    .dmem_addr    (dmem_addr),
    .dmem_rdata   (dmem_rdata),
    .dmem_wdata   (dmem_wdata),
    .dmem_we      (dmem_we),
    .res          (res),
    .halt         (halt),
    .trace_pc     (trace_pc),
    .trace_insn   (trace_insn),
    .trace_status (trace_status)
  );

endmodule

/* hw/rv_mem_wb.sv */
`timescale 1ns/1ps

// memory and writeback stages, data port and trace
module rv_mem_wb (
  input  logic                  clk,
  input  logic                  rst,
  input  rv_pkg::insn_t         x_insn,
  input  rv_pkg::word_t         x_pc,
  input  rv_pkg::cycle_status_e x_status,
  input  rv_pkg::word_t         x_result,
  input  rv_pkg::word_t         x_store_data,
  output rv_pkg::word_t         dmem_addr,
  input  rv_pkg::word_t         dmem_rdata,
  output rv_pkg::word_t         dmem_wdata,
  output rv_pkg::byte_en_t      dmem_we,
  rv_result_if.producer         res,
  output logic                  halt,
  output rv_pkg::word_t         trace_pc,
  output rv_pkg::insn_t         trace_insn,
  output rv_pkg::cycle_status_e trace_status
);

  rv_pkg::word_t         m_pc;
  rv_pkg::insn_t         m_insn;
  rv_pkg::cycle_status_e m_status;
  rv_pkg::word_t         m_result;
  rv_pkg::word_t         m_store_data;
  rv_pkg::opcode_t       m_opcode;
  rv_pkg::funct3_t       m_funct3;
  rv_pkg::reg_idx_t      m_rs2;
  rv_pkg::word_t         m_value;
  logic                  m_wr;
  rv_pkg::word_t         w_pc;
  rv_pkg::insn_t         w_insn;
  rv_pkg::cycle_status_e w_status;
  rv_pkg::word_t         w_data;
  logic                  w_wr;

  // opcodes that leave a value in rd
  function automatic logic writes_rd(input rv_pkg::opcode_t opc,
                                     input rv_pkg::cycle_status_e st);
    return (st == rv_pkg::CYCLE_NO_STALL) &&
           (opc == rv_pkg::OPC_LUI || opc == rv_pkg::OPC_REG_IMM ||
            opc == rv_pkg::OPC_REG_REG || opc == rv_pkg::OPC_LOAD);
  endfunction

  always_ff @(posedge clk) begin
    if (rst) begin
      m_pc     <= '0;
      m_insn   <= '0;
      m_status <= rv_pkg::CYCLE_RESET;
    end else begin
      m_pc     <= x_pc;
      m_insn   <= x_insn;
      m_status <= x_status;
    end
  end

  always_ff @(posedge clk) begin
    m_result     <= x_result;
    m_store_data <= x_store_data;
  end

  assign m_opcode = m_insn[6:0];
  assign m_funct3 = m_insn[14:12];
  assign m_rs2    = m_insn[24:20];
  assign m_wr     = writes_rd(m_opcode, m_status);

  // read data is back by the falling edge of this cycle
  assign m_value = (m_opcode == rv_pkg::OPC_LOAD) ? dmem_rdata : m_result;

  assign dmem_addr = m_result;
  assign dmem_we   = (m_status == rv_pkg::CYCLE_NO_STALL && m_opcode == rv_pkg::OPC_STORE &&
                      m_funct3 == 3'b010) ? 4'b1111 : 4'b0000;
  // store source about to be written by writeback
  assign dmem_wdata = (w_wr && res.w_rd == m_rs2 && m_rs2 != 5'd0) ? w_data : m_store_data;

  always_ff @(posedge clk) begin
    if (rst) begin
      w_pc     <= '0;
      w_insn   <= '0;
      w_status <= rv_pkg::CYCLE_RESET;
    end else begin
      w_pc     <= m_pc;
      w_insn   <= m_insn;
      w_status <= m_status;
    end
  end

  always_ff @(posedge clk) begin
    w_data <= m_value;
  end

  assign w_wr = writes_rd(w_insn[6:0], w_status);

  assign res.m_wr   = m_wr;
  assign res.m_rd   = m_insn[11:7];
  assign res.m_data = m_value;
  assign res.w_wr   = w_wr;
  assign res.w_rd   = w_insn[11:7];
  assign res.w_data = w_data;

  // plain ecall only, every operand field zero
  assign halt = (w_status == rv_pkg::CYCLE_NO_STALL) &&
                (w_insn[6:0] == rv_pkg::OPC_ENVIRON) && (w_insn[31:7] == 25'd0);

  assign trace_pc     = w_pc;
  assign trace_insn   = w_insn;
  assign trace_status = w_status;

endmodule

/* hw/rv_execute.sv */
`timescale 1ns/1ps

// decode/execute register, operand bypass, alu and branch unit
module rv_execute (
  input  logic                  clk,
  input  logic                  rst,
  input  rv_pkg::word_t         d_pc,
  input  rv_pkg::insn_t         d_insn,
  input  rv_pkg::cycle_status_e d_status,
  output rv_pkg::reg_idx_t      rs1,
  output rv_pkg::reg_idx_t      rs2,
  input  rv_pkg::word_t         rs1_data,
  input  rv_pkg::word_t         rs2_data,
  rv_result_if.consumer         res,
  output logic                  flush,
  output rv_pkg::word_t         target,
  output rv_pkg::insn_t         x_insn,
  output rv_pkg::word_t         x_pc,
  output rv_pkg::cycle_status_e x_status,
  output rv_pkg::word_t         x_result,
  output rv_pkg::word_t         x_store_data
);

  rv_pkg::word_t    d_op1;
  rv_pkg::word_t    d_op2;
  rv_pkg::word_t    x_op1_q;
  rv_pkg::word_t    x_op2_q;
  rv_pkg::opcode_t  x_opcode;
  rv_pkg::funct3_t  x_funct3;
  rv_pkg::reg_idx_t x_rs1;
  rv_pkg::reg_idx_t x_rs2;
  rv_pkg::word_t    imm_i;
  rv_pkg::word_t    imm_s;
  rv_pkg::word_t    imm_b;
  rv_pkg::word_t    op1;
  rv_pkg::word_t    op2;
  rv_pkg::word_t    alu_b;
  logic             is_sub;
  logic             cond;

  // pick the youngest in-flight value for a source register
  function automatic rv_pkg::word_t bypass(
    input rv_pkg::reg_idx_t src,
    input rv_pkg::word_t    fallback,
    input logic             m_wr,
    input rv_pkg::reg_idx_t m_rd,
    input rv_pkg::word_t    m_data,
    input logic             w_wr,
    input rv_pkg::reg_idx_t w_rd,
    input rv_pkg::word_t    w_data
  );
    rv_pkg::word_t val;
    val = fallback;
    if (src != 5'd0) begin
      if (m_wr && m_rd == src) begin
        val = m_data;
      end else if (w_wr && w_rd == src) begin
        val = w_data;
      end
    end
    return val;
  endfunction

  assign rs1 = d_insn[19:15];
  assign rs2 = d_insn[24:20];

  // writeback lands this edge so the register file read is stale
  assign d_op1 = (res.w_wr && res.w_rd == rs1 && rs1 != 5'd0) ? res.w_data : rs1_data;
  assign d_op2 = (res.w_wr && res.w_rd == rs2 && rs2 != 5'd0) ? res.w_data : rs2_data;

  always_ff @(posedge clk) begin
    if (rst) begin
      x_pc     <= '0;
      x_insn   <= '0;
      x_status <= rv_pkg::CYCLE_RESET;
    end else if (flush) begin
      x_pc     <= '0;
      x_insn   <= '0;
      x_status <= rv_pkg::CYCLE_TAKEN_BRANCH;
    end else begin
      x_pc     <= d_pc;
      x_insn   <= d_insn;
      x_status <= d_status;
    end
  end

  always_ff @(posedge clk) begin
    x_op1_q <= d_op1;
    x_op2_q <= d_op2;
  end

  assign x_opcode = x_insn[6:0];
  assign x_funct3 = x_insn[14:12];
  assign x_rs1    = x_insn[19:15];
  assign x_rs2    = x_insn[24:20];

  assign imm_i = {{20{x_insn[31]}}, x_insn[31:20]};
  assign imm_s = {{20{x_insn[31]}}, x_insn[31:25], x_insn[11:7]};
  assign imm_b = {{20{x_insn[31]}}, x_insn[7], x_insn[30:25], x_insn[11:8], 1'b0};

  // memory stage wins over writeback
  assign op1 = bypass(x_rs1, x_op1_q, res.m_wr, res.m_rd, res.m_data,
                      res.w_wr, res.w_rd, res.w_data);
  assign op2 = bypass(x_rs2, x_op2_q, res.m_wr, res.m_rd, res.m_data,
                      res.w_wr, res.w_rd, res.w_data);

  // register and immediate forms share the alu
  // immediate shifts take their amount from imm_i[4:0]
  assign alu_b  = (x_opcode == rv_pkg::OPC_REG_REG) ? op2 : imm_i;
  assign is_sub = (x_opcode == rv_pkg::OPC_REG_REG) && x_insn[30];

  always_comb begin
    x_result = '0;
    case (x_opcode)
      rv_pkg::OPC_LUI: x_result = {x_insn[31:12], 12'b0};
      rv_pkg::OPC_REG_IMM, rv_pkg::OPC_REG_REG: begin
        case (x_funct3)
          3'b000: x_result = is_sub ? op1 - alu_b : op1 + alu_b;
          3'b001: x_result = op1 << alu_b[4:0];
          3'b010: x_result = {31'b0, $signed(op1) < $signed(alu_b)};
          3'b011: x_result = {31'b0, op1 < alu_b};
          3'b100: x_result = op1 ^ alu_b;
          3'b101: begin
            if (x_insn[30]) begin
              x_result = $signed(op1) >>> alu_b[4:0];
            end else begin
              x_result = op1 >> alu_b[4:0];
            end
          end
          3'b110: x_result = op1 | alu_b;
          default: x_result = op1 & alu_b;
        endcase
      end
      // effective address
      rv_pkg::OPC_LOAD: x_result = op1 + imm_i;
      rv_pkg::OPC_STORE: x_result = op1 + imm_s;
      default: x_result = '0;
    endcase
  end

  always_comb begin
    case (x_funct3)
      3'b000: cond = op1 == op2;
      3'b001: cond = op1 != op2;
      3'b100: cond = $signed(op1) < $signed(op2);
      3'b101: cond = $signed(op1) >= $signed(op2);
      3'b110: cond = op1 < op2;
      3'b111: cond = op1 >= op2;
      default: cond = 1'b0;
    endcase
  end

  // a squashed branch must not redirect
  assign flush = (x_opcode == rv_pkg::OPC_BRANCH) && cond &&
                 (x_status != rv_pkg::CYCLE_TAKEN_BRANCH);
  assign target = x_pc + imm_b;

  assign x_store_data = op2;

endmodule

/* hw/rv_regfile.sv */
`timescale 1ns/1ps

// 32 x 32 register file, two read ports, one write port
module rv_regfile (
  input  logic             clk,
  input  logic             rst,
  input  rv_pkg::reg_idx_t rs1,
  input  rv_pkg::reg_idx_t rs2,
  output rv_pkg::word_t    rs1_data,
  output rv_pkg::word_t    rs2_data,
  rv_result_if.consumer    res
);

  rv_pkg::word_t regs [rv_pkg::NUM_REGS];

  // x0 is cleared by reset and never written
  assign rs1_data = regs[rs1];
  assign rs2_data = regs[rs2];

  always_ff @(posedge clk) begin
    if (rst) begin
      for (int i = 0; i < rv_pkg::NUM_REGS; i++) begin
        regs[i] <= '0;
      end
    end else if (res.w_wr && res.w_rd != 5'd0) begin
      regs[res.w_rd] <= res.w_data;
    end
  end

endmodule

/* hw/rv_frontend.sv */
`timescale 1ns/1ps

// fetch stage and the fetch/decode register
module rv_frontend #(
  parameter rv_pkg::word_t RESET_PC = 32'h0000_0000
) (
  input  logic                  clk,
  input  logic                  rst,
  input  logic                  flush,
  input  rv_pkg::word_t         target,
  output rv_pkg::word_t         pc,
  input  rv_pkg::insn_t         insn,
  output rv_pkg::word_t         d_pc,
  output rv_pkg::insn_t         d_insn,
  output rv_pkg::cycle_status_e d_status
);

  rv_pkg::word_t pc_next;

  // no prediction, straight-line fetch unless execute redirects
  assign pc_next = flush ? target : pc + 32'd4;

  always_ff @(posedge clk) begin
    if (rst) begin
      pc <= RESET_PC;
    end else begin
      pc <= pc_next;
    end
  end

  // insn arrived by the falling edge, latch it for decode
  always_ff @(posedge clk) begin
    if (rst) begin
      d_pc     <= '0;
      d_insn   <= '0;
      d_status <= rv_pkg::CYCLE_RESET;
    end else if (flush) begin
      // squash the wrong-path fetch
      d_pc     <= '0;
      d_insn   <= '0;
      d_status <= rv_pkg::CYCLE_TAKEN_BRANCH;
    end else begin
      d_pc     <= pc;
      d_insn   <= insn;
      d_status <= rv_pkg::CYCLE_NO_STALL;
    end
  end

endmodule

/* hw/rv_result_if.sv */
`timescale 1ns/1ps

// results of the memory and writeback stages, fed back to earlier stages
interface rv_result_if;

  // memory stage, load data already selected
  logic             m_wr;
  rv_pkg::reg_idx_t m_rd;
  rv_pkg::word_t    m_data;

  // writeback stage, also the register file write port
  logic             w_wr;
  rv_pkg::reg_idx_t w_rd;
  rv_pkg::word_t    w_data;

  modport producer (
    output m_wr, m_rd, m_data,
    output w_wr, w_rd, w_data
  );

  modport consumer (
    input m_wr, m_rd, m_data,
    input w_wr, w_rd, w_data
  );

endinterface

/* hw/rv_pkg.sv */
package rv_pkg;

  // data word, pc and byte address share one width
  typedef logic [31:0] word_t;

  typedef logic [31:0] insn_t;

  typedef logic [4:0] reg_idx_t;

  // major opcode, insn[6:0]
  typedef logic [6:0] opcode_t;

  // minor opcode, insn[14:12]
  typedef logic [2:0] funct3_t;

  // one enable per byte of a store
  typedef logic [3:0] byte_en_t;

  parameter int NUM_REGS = 32;

  // major opcodes used by this core
  parameter opcode_t OPC_LUI = 7'b01_101_11;

  parameter opcode_t OPC_REG_IMM = 7'b00_100_11;

  parameter opcode_t OPC_REG_REG = 7'b01_100_11;

  parameter opcode_t OPC_BRANCH = 7'b11_000_11;

  parameter opcode_t OPC_LOAD = 7'b00_000_11;

  parameter opcode_t OPC_STORE = 7'b01_000_11;

  parameter opcode_t OPC_ENVIRON = 7'b11_100_11;

  // what occupies a stage on a given cycle
  // one-hot values, so a stray code is easy to spot in a waveform
  typedef enum logic [2:0] {
    // bubble left behind by reset
    CYCLE_RESET        = 3'b001,
    // a real instruction
    CYCLE_NO_STALL     = 3'b010,
    // bubble made by a taken-branch flush
    CYCLE_TAKEN_BRANCH = 3'b100
  } cycle_status_e;

endpackage
